// ==== uart_pkg.sv ====
//**************************************************************************
// Shared definitions for the memory-mapped UART: character and divisor
// widths, the register index and the bit layout of each register.
//**************************************************************************
package uart_pkg;

    parameter int BAUD_W = 32;
    parameter int DATA_W = 8;

    // Register index, taken from address bits 3:2.
    typedef enum logic [1:0] {
        CTRL_0  = 2'd0,
        CTRL_1  = 2'd1,
        DATA_TX = 2'd2,
        DATA_RX = 2'd3
    } uart_reg_t;

    typedef struct packed {
        logic [BAUD_W-1:0] baud;        // Clocks per bit.
    } uart_ctrl_0_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        rst_n;             // Low holds both engines idle.
    } uart_ctrl_1_t;

    typedef struct packed {
        logic [31-DATA_W-1:0] rsvd;
        logic                 tx_flag;  // Transmitter idle.
        logic [DATA_W-1:0]    tx_data;
    } uart_data_tx_t;

    typedef struct packed {
        logic [31-DATA_W-1:0] rsvd;
        logic                 rx_flag;  // Byte waiting to be read.
        logic [DATA_W-1:0]    rx_data;
    } uart_data_rx_t;

endpackage

// ==== uart_tx.sv ====
//**************************************************************************
// UART transmitter: one start bit, eight data bits LSB first, one stop
// bit, each held for the programmed number of clocks.
//**************************************************************************
`timescale 1ns/1ns

module uart_tx (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        init_i,
    output logic                        done_o,
    input  logic [uart_pkg::DATA_W-1:0] data_i,
    output logic                        data_o,
    input  logic [uart_pkg::BAUD_W-1:0] baud_div_i
);

    localparam int IDX_W = $clog2(uart_pkg::DATA_W);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t                   state;
    logic [uart_pkg::BAUD_W-1:0] cnt;
    logic [IDX_W-1:0]            bit_idx;
    logic [uart_pkg::DATA_W-1:0] shreg;
    logic                        bit_end;

    assign bit_end = (cnt == baud_div_i - 1'b1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            shreg   <= '0;
            data_o  <= 1'b1;
            done_o  <= 1'b0;
        end else if (!en_i) begin
            state   <= TX_IDLE;         // Soft reset from CTRL_1.
            cnt     <= '0;
            bit_idx <= '0;
            shreg   <= '0;
            data_o  <= 1'b1;
            done_o  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt    <= '0;
                    done_o <= 1'b1;
                    if (init_i) begin
                        shreg  <= data_i;
                        data_o <= 1'b0;     // Start bit.
                        done_o <= 1'b0;
                        state  <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        data_o  <= shreg[0];
                        shreg   <= shreg >> 1;
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == IDX_W'(uart_pkg::DATA_W - 1)) begin
                            data_o <= 1'b1; // Stop bit.
                            state  <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            data_o  <= shreg[0];
                            shreg   <= shreg >> 1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        cnt    <= '0;
                        done_o <= 1'b1;
                        state  <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== uart_rx.sv ====
//**************************************************************************
// UART receiver: input synchronizer, start-bit check at half a bit,
// mid-bit sampling, and a hold state that keeps the byte until acked.
//**************************************************************************
`timescale 1ns/1ns

module uart_rx (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        init_i,
    output logic                        done_o,
    input  logic                        data_i,
    output logic [uart_pkg::DATA_W-1:0] data_o,
    input  logic [uart_pkg::BAUD_W-1:0] baud_div_i
);

    localparam int IDX_W = $clog2(uart_pkg::DATA_W);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_HOLD
    } rx_state_t;

    rx_state_t                   state;
    logic                        rx_s1;
    logic                        rx_s2;
    logic [uart_pkg::BAUD_W-1:0] cnt;
    logic [IDX_W-1:0]            bit_idx;
    logic [uart_pkg::DATA_W-1:0] shreg;
    logic                        bit_end;
    logic                        half_end;

    assign bit_end  = (cnt == baud_div_i - 1'b1);
    assign half_end = (cnt == (baud_div_i >> 1) - 1'b1);

    // Line idles high.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
        end else begin
            rx_s1 <= data_i;
            rx_s2 <= rx_s1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            shreg   <= '0;
            data_o  <= '0;
            done_o  <= 1'b0;
        end else if (!en_i) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            shreg   <= '0;
            data_o  <= '0;
            done_o  <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s2) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s2 ? RX_IDLE : RX_DATA;  // Glitch is a false start.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        shreg <= {rx_s2, shreg[uart_pkg::DATA_W-1:1]};   // LSB first.
                        if (bit_idx == IDX_W'(uart_pkg::DATA_W - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (rx_s2) begin
                            data_o <= shreg;
                            done_o <= 1'b1;
                            state  <= RX_HOLD;
                        end else begin
                            state <= RX_IDLE;           // Framing error.
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // Line is ignored here, so a new frame is lost.
                    if (init_i) begin
                        done_o <= 1'b0;
                        state  <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== mmio_uart.sv ====
//**************************************************************************
// Memory-mapped UART: bus decode, CTRL_0/CTRL_1/DATA_TX/DATA_RX register
// file, registered read port, and the transmitter and receiver engines.
//**************************************************************************
`timescale 1ns/1ns

module mmio_uart #(
    parameter int               XLEN = 32,
    parameter logic [XLEN-1:0]  BASE = 32'h4000_0000
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic [XLEN-1:0]     rd_addr_i,
    output logic [XLEN-1:0]     rd_data_o,
    output logic                rd_valid_o,

    input  logic [XLEN-1:0]     wr_addr_i,
    input  logic [XLEN-1:0]     wr_data_i,
    input  logic [XLEN/8-1:0]   wr_byte_en_i,

    input  logic                rx_i,
    output logic                tx_o
);

    logic                          rd_sel;
    logic                          wr_sel;
    uart_pkg::uart_reg_t           rd_idx;
    uart_pkg::uart_reg_t           wr_idx;

    uart_pkg::uart_ctrl_0_t        ctrl_0;
    logic                          ctrl_1_rst_n;
    uart_pkg::uart_ctrl_1_t        ctrl_1;
    uart_pkg::uart_data_tx_t       data_tx;
    uart_pkg::uart_data_rx_t       data_rx;
    logic [XLEN-1:0]               rd_mux;

    logic [uart_pkg::DATA_W-1:0]   tx_data;
    logic                          tx_init_q;
    logic                          tx_busy;
    logic                          tx_init;
    logic                          tx_done;

    logic [uart_pkg::DATA_W-1:0]   rx_data;
    logic                          rx_done;
    logic                          rx_ack;

    assign rd_sel = (rd_addr_i[XLEN-1:8] == BASE[XLEN-1:8]);
    assign wr_sel = (wr_addr_i[XLEN-1:8] == BASE[XLEN-1:8]) && (|wr_byte_en_i);
    assign rd_idx = uart_pkg::uart_reg_t'(rd_addr_i[3:2]);
    assign wr_idx = uart_pkg::uart_reg_t'(wr_addr_i[3:2]);

    // Init drops in the cycle the frame completes, so the engine does not restart.
    assign tx_init = tx_init_q & ~(tx_busy & tx_done);

    always_comb begin
        ctrl_1          = '0;
        ctrl_1.rst_n    = ctrl_1_rst_n;
        data_tx         = '0;
        data_tx.tx_flag = tx_done;
        data_tx.tx_data = tx_data;
        data_rx         = '0;
        data_rx.rx_flag = rx_done;
        data_rx.rx_data = rx_data;
        case (rd_idx)
            uart_pkg::CTRL_0:  rd_mux = XLEN'(ctrl_0);
            uart_pkg::CTRL_1:  rd_mux = XLEN'(ctrl_1);
            uart_pkg::DATA_TX: rd_mux = XLEN'(data_tx);
            default:           rd_mux = XLEN'(data_rx);
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_0       <= '0;
            ctrl_1_rst_n <= 1'b0;
            tx_data      <= '0;
            tx_init_q    <= 1'b0;
            tx_busy      <= 1'b0;
        end else begin
            if (tx_init_q && !tx_done) begin
                tx_busy <= 1'b1;                // Engine took the byte.
            end
            if (tx_busy && tx_done) begin
                tx_init_q <= 1'b0;
                tx_busy   <= 1'b0;
            end
            if (wr_sel) begin
                case (wr_idx)
                    uart_pkg::CTRL_0: begin
                        ctrl_0.baud <= wr_data_i[uart_pkg::BAUD_W-1:0];
                    end
                    uart_pkg::CTRL_1: begin
                        ctrl_1_rst_n <= wr_data_i[0];
                    end
                    uart_pkg::DATA_TX: begin
                        tx_data   <= wr_data_i[uart_pkg::DATA_W-1:0];
                        tx_init_q <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            if (!ctrl_1_rst_n) begin
                tx_init_q <= 1'b0;              // Pending frame is dropped.
                tx_busy   <= 1'b0;
            end
        end
    end

    // Ack is held until the receiver lets go of done.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_ack <= 1'b0;
        end else if (!rx_done) begin
            rx_ack <= 1'b0;
        end else if (rd_sel && rd_idx == uart_pkg::DATA_RX) begin
            rx_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_sel;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_sel) begin
            rd_data_o <= rd_mux;
        end
    end

    uart_tx u_uart_tx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (ctrl_1_rst_n),
        .init_i     (tx_init),
        .done_o     (tx_done),
        .data_i     (tx_data),
        .data_o     (tx_o),
        .baud_div_i (ctrl_0.baud)
    );

    uart_rx u_uart_rx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (ctrl_1_rst_n),
        .init_i     (rx_ack),
        .done_o     (rx_done),
        .data_i     (rx_i),
        .data_o     (rx_data),
        .baud_div_i (ctrl_0.baud)
    );

endmodule

// ==== tb_mmio_uart.sv ====
//**************************************************************************
// Testbench for the memory-mapped UART: register access, transmit frame
// shape, loopback receive and soft reset in the middle of a frame.
//**************************************************************************
`timescale 1ns/1ns

module tb_mmio_uart;

    localparam logic [31:0] BASE     = 32'h4000_0000;
    localparam int          BAUD_DIV = 8;
    localparam int          FRAME    = 10 * BAUD_DIV;
    localparam int          RD_WAIT  = 4;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic [31:0] rd_addr_i;
    logic [31:0] rd_data_o;
    logic        rd_valid_o;
    logic [31:0] wr_addr_i;
    logic [31:0] wr_data_i;
    logic [3:0]  wr_byte_en_i;
    logic        tx_o;

    int          errors = 0;
    int          timeouts = 0;
    int          cycles = 0;
    int          seed = 30;
    logic [7:0]  tx_byte;

    mmio_uart #(.XLEN(32), .BASE(BASE)) uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .rd_valid_o   (rd_valid_o),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .wr_byte_en_i (wr_byte_en_i),
        .rx_i         (tx_o),           // Loopback.
        .tx_o         (tx_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) cycles++;

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_in_time(input logic ok, input string what);
        assert (ok) else begin
            timeouts++;
            $display("%s", what);
        end
    endtask

    // Writes take effect at the next rising edge.
    task automatic bus_write(input uart_pkg::uart_reg_t idx, input logic [31:0] data,
                             input logic [3:0] be, input logic [31:0] base);
        wr_addr_i    = base | {28'd0, idx, 2'b00};
        wr_data_i    = data;
        wr_byte_en_i = be;
        @(negedge clk_i);
        wr_addr_i    = 32'h0;
        wr_byte_en_i = 4'h0;
        @(negedge clk_i);               // Lets the engines see the new value.
    endtask

    task automatic bus_read(input uart_pkg::uart_reg_t idx, output logic [31:0] data);
        int n;
        n = 0;
        check_eq("rd_valid_o", 32'(rd_valid_o), 32'h0);  // Nothing selected the cycle before.
        rd_addr_i = BASE | {28'd0, idx, 2'b00};
        do begin
            @(negedge clk_i);
            n++;
        end while (!rd_valid_o && n < RD_WAIT);
        check_in_time(rd_valid_o, "Read data valid never came after a read address");
        check_eq("read latency", 32'(n), 32'd1);
        data      = rd_data_o;
        rd_addr_i = 32'h0;
        @(negedge clk_i);               // Room for the receive ack to clear.
    endtask

    task automatic wait_flag(input uart_pkg::uart_reg_t idx, input int limit,
                             input string what, output logic [31:0] data);
        int start;
        start = cycles;
        do begin
            bus_read(idx, data);
        end while (!data[8] && cycles - start < limit);
        check_in_time(data[8], what);
    endtask

    // Samples the line at each mid-bit, counted from the start edge.
    task automatic capture_frame(input logic [7:0] exp);
        int n;
        n = 0;
        while (tx_o && n < 4 * BAUD_DIV) begin
            @(negedge clk_i);
            n++;
        end
        check_in_time(!tx_o, "No start bit appeared on the serial line");
        repeat (BAUD_DIV / 2) @(negedge clk_i);
        check_eq("tx_o start bit", 32'(tx_o), 32'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk_i);
            check_eq("tx_o data bit", 32'(tx_o), 32'(exp[i]));
        end
        repeat (BAUD_DIV) @(negedge clk_i);
        check_eq("tx_o stop bit", 32'(tx_o), 32'h1);
    endtask

    initial begin
        logic [31:0] val;
        rst_n_i      = 1'b0;
        rd_addr_i    = 32'h0;
        wr_addr_i    = 32'h0;
        wr_data_i    = 32'h0;
        wr_byte_en_i = 4'h0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        bus_read(uart_pkg::CTRL_0, val);
        check_eq("CTRL_0", val, 32'h0);
        bus_read(uart_pkg::CTRL_1, val);
        check_eq("CTRL_1", val, 32'h0);
        bus_read(uart_pkg::DATA_TX, val);
        check_eq("tx_flag", 32'(val[8]), 32'h0);
        bus_read(uart_pkg::DATA_RX, val);
        check_eq("rx_flag", 32'(val[8]), 32'h0);

        bus_write(uart_pkg::CTRL_0, 32'h1234_5678, 4'hf, BASE);
        bus_read(uart_pkg::CTRL_0, val);
        check_eq("CTRL_0", val, 32'h1234_5678);
        bus_write(uart_pkg::CTRL_0, 32'hdead_beef, 4'h0, BASE);
        bus_read(uart_pkg::CTRL_0, val);
        check_eq("CTRL_0", val, 32'h1234_5678);
        bus_write(uart_pkg::CTRL_0, 32'hdead_beef, 4'hf, BASE + 32'h100);
        bus_read(uart_pkg::CTRL_0, val);
        check_eq("CTRL_0", val, 32'h1234_5678);
        rd_addr_i = BASE + 32'h100;     // Outside the peripheral.
        repeat (2) @(negedge clk_i);
        check_eq("rd_valid_o", 32'(rd_valid_o), 32'h0);
        rd_addr_i = 32'h0;

        bus_write(uart_pkg::CTRL_0, BAUD_DIV, 4'hf, BASE);
        bus_write(uart_pkg::CTRL_1, 32'h1, 4'hf, BASE);
        bus_read(uart_pkg::DATA_TX, val);
        check_eq("tx_flag", 32'(val[8]), 32'h1);

        for (int k = 0; k < 4; k++) begin
            tx_byte = 8'($random(seed));
            fork
                capture_frame(tx_byte);
                begin
                    bus_write(uart_pkg::DATA_TX, {24'd0, tx_byte}, 4'h1 << k, BASE);
                    bus_read(uart_pkg::DATA_TX, val);
                    check_eq("tx_flag", 32'(val[8]), 32'h0);
                    wait_flag(uart_pkg::DATA_TX, 12 * FRAME,
                              "Transmitter did not return to idle in time", val);
                end
            join
            wait_flag(uart_pkg::DATA_RX, 2 * FRAME, "No byte arrived over loopback", val);
            check_eq("rx_data", 32'(val[7:0]), 32'(tx_byte));
            bus_read(uart_pkg::DATA_RX, val);
            check_eq("rx_flag", 32'(val[8]), 32'h0);
        end

        // Soft reset cuts a frame short.
        tx_byte = 8'($random(seed));
        bus_write(uart_pkg::DATA_TX, {24'd0, tx_byte}, 4'hf, BASE);
        repeat (3 * BAUD_DIV) @(negedge clk_i);
        bus_write(uart_pkg::CTRL_1, 32'h0, 4'hf, BASE);
        for (int i = 0; i < FRAME; i++) begin
            check_eq("tx_o", 32'(tx_o), 32'h1);
            @(negedge clk_i);
        end
        bus_read(uart_pkg::DATA_TX, val);
        check_eq("tx_flag", 32'(val[8]), 32'h0);
        bus_read(uart_pkg::DATA_RX, val);
        check_eq("rx_flag", 32'(val[8]), 32'h0);

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
mmio_uart.sv
tb_mmio_uart.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_mmio_uart
FILELIST  = vlog.f
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
